/* hdl/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath and register file
`define MIPS_NB_DATA     32
`define MIPS_NB_REG      5
`define MIPS_N_REGISTER  32

// both memories are word addressed
`define MIPS_IM_DEPTH    64
`define MIPS_DM_DEPTH    64
`define MIPS_ADDRWIDTH   6

`endif

/* hdl/isa_pkg.sv */
`default_nettype none

`include "mips_defs.svh"

package isa_pkg;

	typedef enum logic [5:0] {
		R_TYPE = 6'b000000,
		J      = 6'b000010,
		BEQ    = 6'b000100,
		BNE    = 6'b000101,
		ADDIU  = 6'b001001,
		ANDI   = 6'b001100,
		ORI    = 6'b001101,
		LUI    = 6'b001111,
		LW     = 6'b100011,
		SW     = 6'b101011,
		HALT   = 6'b111111
	} opcode_e;

	typedef enum logic [5:0] {
		SLL  = 6'b000000,
		ADDU = 6'b100001,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		XOR  = 6'b100110,
		SLT  = 6'b101010
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_e;

	// imm16 is bits [15:0], jump target bits [25:0]
	typedef struct packed {
		opcode_e                  opcode;
		logic [`MIPS_NB_REG-1:0]  rs;
		logic [`MIPS_NB_REG-1:0]  rt;
		logic [`MIPS_NB_REG-1:0]  rd;
		logic [`MIPS_NB_REG-1:0]  shamt;
		funct_e                   funct;
	} instr_t;

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none

`include "mips_defs.svh"

package pipe_pkg;

	typedef struct packed {
		isa_pkg::instr_t             instruction;
		logic [`MIPS_ADDRWIDTH-1:0]  pc_plus1;
	} if_id_t;

	typedef struct packed {
		logic                        valid;
		isa_pkg::alu_op_e            alu_op;
		logic                        alu_src_imm;   // b operand is imm_ext
		logic [`MIPS_NB_REG-1:0]     shamt;
		logic [`MIPS_NB_REG-1:0]     rs;
		logic [`MIPS_NB_REG-1:0]     rt;
		logic [`MIPS_NB_REG-1:0]     write_reg;
		logic [`MIPS_NB_DATA-1:0]    data_ra;
		logic [`MIPS_NB_DATA-1:0]    data_rb;
		logic [`MIPS_NB_DATA-1:0]    imm_ext;
		logic                        mem_read;
		logic                        mem_write;
		logic                        reg_write;
		logic                        mem_to_reg;
		logic                        halt;
	} id_ex_t;

	typedef struct packed {
		logic                        valid;
		logic [`MIPS_NB_DATA-1:0]    alu_result;    // also the data word address
		logic [`MIPS_NB_DATA-1:0]    store_data;
		logic [`MIPS_NB_REG-1:0]     write_reg;
		logic                        mem_read;
		logic                        mem_write;
		logic                        reg_write;
		logic                        mem_to_reg;
		logic                        halt;
	} ex_mem_t;

	// writeback port of the register file
	typedef struct packed {
		logic                        reg_write;
		logic [`MIPS_NB_REG-1:0]     write_reg;
		logic [`MIPS_NB_DATA-1:0]    write_data;
	} wb_t;

	typedef struct packed {
		logic                        reg_write;     // never set for loads
		logic [`MIPS_NB_REG-1:0]     write_reg;
		logic [`MIPS_NB_DATA-1:0]    data;
	} fwd_t;

endpackage

`default_nettype wire

/* hdl/run_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module run_ctrl (
	input  wire   clock,
	input  wire   i_arst_n,
	input  wire   i_start,
	input  wire   i_wb_halt,
	output logic  o_run_en,
	output logic  o_restart,
	output logic  o_halt
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HALTED
	} state_e;

	state_e state_q;

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE, HALTED: begin
					if (i_start)
						state_q <= RUN;
				end
				RUN: begin
					if (i_wb_halt)
						state_q <= HALTED;   // HALT reached writeback
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// clears PC and valid bits on the edge that enters RUN
	assign o_restart = i_start && (state_q != RUN);
	assign o_run_en  = (state_q == RUN);
	assign o_halt    = (state_q == HALTED);

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module fetch_stage (
	input  wire                         clock,
	input  wire                         i_arst_n,
	input  wire                         i_run_en,
	input  wire                         i_restart,
	input  wire                         i_stall,
	input  wire                         i_redirect,
	input  wire [`MIPS_ADDRWIDTH-1:0]   i_redirect_pc,
	input  wire                         i_im_we,
	input  wire [`MIPS_ADDRWIDTH-1:0]   i_im_addr,
	input  wire [`MIPS_NB_DATA-1:0]     i_im_data,
	output pipe_pkg::if_id_t            o_if_id,
	output logic [`MIPS_ADDRWIDTH-1:0]  o_pc
);

	logic [`MIPS_NB_DATA-1:0]   imem [`MIPS_IM_DEPTH];
	logic [`MIPS_ADDRWIDTH-1:0] pc_q;
	logic [`MIPS_ADDRWIDTH-1:0] pc_plus1;
	pipe_pkg::if_id_t           if_id_q;

	// loader only while the core is stopped
	always_ff @(posedge clock) begin
		if (i_im_we && !i_run_en)
			imem[i_im_addr] <= i_im_data;
	end

	assign pc_plus1 = pc_q + 1'b1;

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc_q    <= '0;
			if_id_q <= '0;
		end else if (i_restart) begin
			pc_q    <= '0;
			if_id_q <= '0;                      // all zero word is a NOP
		end else if (i_run_en) begin
			if (i_redirect) begin
				pc_q    <= i_redirect_pc;
				if_id_q <= '0;                  // squash wrong-path fetch
			end else if (!i_stall) begin
				pc_q                <= pc_plus1;
				if_id_q.instruction <= isa_pkg::instr_t'(imem[pc_q]);
				if_id_q.pc_plus1    <= pc_plus1;
			end
		end
	end

	assign o_if_id = if_id_q;
	assign o_pc    = pc_q;

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module decode_stage (
	input  wire                         clock,
	input  wire                         i_arst_n,
	input  wire                         i_run_en,
	input  wire                         i_restart,
	input  pipe_pkg::if_id_t            i_if_id,
	input  pipe_pkg::wb_t               i_wb,
	input  pipe_pkg::fwd_t              i_fwd,
	input  wire [`MIPS_NB_REG-1:0]      i_reg_dbg_addr,
	output pipe_pkg::id_ex_t            o_id_ex,
	output logic                        o_stall,
	output logic                        o_redirect,
	output logic [`MIPS_ADDRWIDTH-1:0]  o_redirect_pc,
	output logic [`MIPS_NB_DATA-1:0]    o_reg_dbg_data
);

	logic [`MIPS_NB_DATA-1:0] regs [`MIPS_N_REGISTER];
	isa_pkg::instr_t          ins;
	logic [15:0]              imm16;
	logic [`MIPS_NB_DATA-1:0] rf_a, rf_b, br_a, br_b;
	pipe_pkg::id_ex_t         ctrl, id_ex_q;
	logic [`MIPS_NB_REG-1:0]  ld_dst_q;   // dest of a load now in EX/MEM
	logic uses_rs, uses_rt, is_beq, is_bne, is_jump, is_halt;
	logic load_use, branch_dep, branch_ld, hazard, taken;

	assign ins   = i_if_id.instruction;
	assign imm16 = ins[15:0];

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < `MIPS_N_REGISTER; i++)
				regs[i] <= '0;
		end else if (i_run_en && i_wb.reg_write && i_wb.write_reg != '0) begin
			regs[i_wb.write_reg] <= i_wb.write_data;
		end
	end

	always_ff @(posedge clock)
		o_reg_dbg_data <= regs[i_reg_dbg_addr];

	// write-before-read bypass, then the EX/MEM result for branches
	assign rf_a = (i_wb.reg_write && i_wb.write_reg != '0 && i_wb.write_reg == ins.rs) ?
		i_wb.write_data : regs[ins.rs];
	assign rf_b = (i_wb.reg_write && i_wb.write_reg != '0 && i_wb.write_reg == ins.rt) ?
		i_wb.write_data : regs[ins.rt];
	assign br_a = (i_fwd.reg_write && i_fwd.write_reg != '0 && i_fwd.write_reg == ins.rs) ?
		i_fwd.data : rf_a;
	assign br_b = (i_fwd.reg_write && i_fwd.write_reg != '0 && i_fwd.write_reg == ins.rt) ?
		i_fwd.data : rf_b;

	always_comb begin
		ctrl             = '0;
		ctrl.valid       = 1'b1;
		ctrl.alu_op      = isa_pkg::ALU_ADD;
		ctrl.shamt       = ins.shamt;
		ctrl.rs          = ins.rs;
		ctrl.rt          = ins.rt;
		ctrl.write_reg   = ins.rt;
		ctrl.data_ra     = rf_a;
		ctrl.data_rb     = rf_b;
		ctrl.imm_ext     = {{16{imm16[15]}}, imm16};
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		is_jump = 1'b0;
		is_halt = 1'b0;
		case (ins.opcode)
			isa_pkg::R_TYPE: begin
				ctrl.write_reg = ins.rd;
				ctrl.reg_write = 1'b1;
				uses_rt        = 1'b1;
				case (ins.funct)
					isa_pkg::ADDU: ctrl.alu_op = isa_pkg::ALU_ADD;
					isa_pkg::SUBU: ctrl.alu_op = isa_pkg::ALU_SUB;
					isa_pkg::AND:  ctrl.alu_op = isa_pkg::ALU_AND;
					isa_pkg::OR:   ctrl.alu_op = isa_pkg::ALU_OR;
					isa_pkg::XOR:  ctrl.alu_op = isa_pkg::ALU_XOR;
					isa_pkg::SLT:  ctrl.alu_op = isa_pkg::ALU_SLT;
					isa_pkg::SLL: begin
						ctrl.alu_op = isa_pkg::ALU_SLL;
						uses_rs     = 1'b0;
					end
					default: ctrl.reg_write = 1'b0;  // unknown funct does nothing
				endcase
			end
			isa_pkg::ADDIU: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::LUI: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.imm_ext     = {16'b0, imm16};  // zero extended
				if (ins.opcode == isa_pkg::ANDI)
					ctrl.alu_op = isa_pkg::ALU_AND;
				else if (ins.opcode == isa_pkg::ORI)
					ctrl.alu_op = isa_pkg::ALU_OR;
				else
					ctrl.alu_op = isa_pkg::ALU_LUI;
				uses_rs = (ins.opcode != isa_pkg::LUI);
			end
			isa_pkg::LW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			isa_pkg::SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
				uses_rt          = 1'b1;
			end
			isa_pkg::BEQ: begin
				is_beq  = 1'b1;
				uses_rt = 1'b1;
			end
			isa_pkg::BNE: begin
				is_bne  = 1'b1;
				uses_rt = 1'b1;
			end
			isa_pkg::J: begin
				is_jump = 1'b1;
				uses_rs = 1'b0;
			end
			isa_pkg::HALT: begin
				ctrl.halt = 1'b1;
				is_halt   = 1'b1;
				uses_rs   = 1'b0;
			end
			default: ctrl.valid = 1'b0;  // illegal opcode becomes a bubble
		endcase
	end

	// hazard detection
	assign load_use = id_ex_q.valid && id_ex_q.mem_read && id_ex_q.write_reg != '0 &&
		((uses_rs && id_ex_q.write_reg == ins.rs) || (uses_rt && id_ex_q.write_reg == ins.rt));
	assign branch_dep = (is_beq || is_bne) && id_ex_q.valid && id_ex_q.reg_write &&
		id_ex_q.write_reg != '0 && (id_ex_q.write_reg == ins.rs || id_ex_q.write_reg == ins.rt);
	// load data is not on the forward path until writeback
	assign branch_ld = (is_beq || is_bne) && ld_dst_q != '0 &&
		(ld_dst_q == ins.rs || ld_dst_q == ins.rt);
	assign hazard = load_use || branch_dep || branch_ld;

	assign taken = is_jump || (is_beq && br_a == br_b) || (is_bne && br_a != br_b);

	assign o_stall       = hazard || is_halt;  // nothing past HALT is fetched
	assign o_redirect    = taken && !hazard;
	assign o_redirect_pc = is_jump ? ins[`MIPS_ADDRWIDTH-1:0] :
		i_if_id.pc_plus1 + imm16[`MIPS_ADDRWIDTH-1:0];

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			id_ex_q  <= '0;
			ld_dst_q <= '0;
		end else if (i_restart) begin
			id_ex_q  <= '0;
			ld_dst_q <= '0;
		end else if (i_run_en) begin
			id_ex_q  <= hazard ? '0 : ctrl;
			ld_dst_q <= (id_ex_q.valid && id_ex_q.mem_read) ? id_ex_q.write_reg : '0;
		end
	end

	assign o_id_ex = id_ex_q;

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module execute_stage (
	input  wire                 clock,
	input  wire                 i_arst_n,
	input  wire                 i_run_en,
	input  wire                 i_restart,
	input  pipe_pkg::id_ex_t    i_id_ex,
	input  pipe_pkg::wb_t       i_wb,
	output pipe_pkg::ex_mem_t   o_ex_mem,
	output pipe_pkg::fwd_t      o_fwd
);

	pipe_pkg::ex_mem_t        ex_mem_d, ex_mem_q;
	logic [`MIPS_NB_DATA-1:0] src_a, src_b, op_b, result;

	// EX/MEM wins over MEM/WB and r0 is never forwarded
	always_comb begin
		if (o_fwd.reg_write && o_fwd.write_reg != '0 && o_fwd.write_reg == i_id_ex.rs)
			src_a = o_fwd.data;
		else if (i_wb.reg_write && i_wb.write_reg != '0 && i_wb.write_reg == i_id_ex.rs)
			src_a = i_wb.write_data;
		else
			src_a = i_id_ex.data_ra;

		if (o_fwd.reg_write && o_fwd.write_reg != '0 && o_fwd.write_reg == i_id_ex.rt)
			src_b = o_fwd.data;
		else if (i_wb.reg_write && i_wb.write_reg != '0 && i_wb.write_reg == i_id_ex.rt)
			src_b = i_wb.write_data;
		else
			src_b = i_id_ex.data_rb;
	end

	assign op_b = i_id_ex.alu_src_imm ? i_id_ex.imm_ext : src_b;

	always_comb begin
		case (i_id_ex.alu_op)
			isa_pkg::ALU_ADD: result = src_a + op_b;
			isa_pkg::ALU_SUB: result = src_a - op_b;
			isa_pkg::ALU_AND: result = src_a & op_b;
			isa_pkg::ALU_OR:  result = src_a | op_b;
			isa_pkg::ALU_XOR: result = src_a ^ op_b;
			isa_pkg::ALU_SLT: result = {{(`MIPS_NB_DATA-1){1'b0}}, $signed(src_a) < $signed(op_b)};
			isa_pkg::ALU_SLL: result = src_b << i_id_ex.shamt;  // shifts rt
			isa_pkg::ALU_LUI: result = {op_b[15:0], 16'b0};
			default:          result = op_b;
		endcase
	end

	always_comb begin
		ex_mem_d.valid      = i_id_ex.valid;
		ex_mem_d.alu_result = result;
		ex_mem_d.store_data = src_b;
		ex_mem_d.write_reg  = i_id_ex.write_reg;
		ex_mem_d.mem_read   = i_id_ex.mem_read;
		ex_mem_d.mem_write  = i_id_ex.mem_write;
		ex_mem_d.reg_write  = i_id_ex.reg_write;
		ex_mem_d.mem_to_reg = i_id_ex.mem_to_reg;
		ex_mem_d.halt       = i_id_ex.halt;
	end

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n)
			ex_mem_q <= '0;
		else if (i_restart)
			ex_mem_q <= '0;
		else if (i_run_en)
			ex_mem_q <= ex_mem_d;
	end

	assign o_ex_mem = ex_mem_q;

	assign o_fwd.reg_write = ex_mem_q.valid && ex_mem_q.reg_write && !ex_mem_q.mem_read;
	assign o_fwd.write_reg = ex_mem_q.write_reg;
	assign o_fwd.data      = ex_mem_q.alu_result;

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module memory_stage (
	input  wire                         clock,
	input  wire                         i_arst_n,
	input  wire                         i_run_en,
	input  wire                         i_restart,
	input  pipe_pkg::ex_mem_t           i_ex_mem,
	input  wire [`MIPS_ADDRWIDTH-1:0]   i_dm_dbg_addr,
	output pipe_pkg::wb_t               o_wb,
	output logic                        o_wb_halt,
	output logic [`MIPS_NB_DATA-1:0]    o_dm_dbg_data
);

	logic [`MIPS_NB_DATA-1:0]   dmem [`MIPS_DM_DEPTH];
	logic [`MIPS_ADDRWIDTH-1:0] addr;
	logic [`MIPS_NB_DATA-1:0]   load_data;
	pipe_pkg::wb_t              wb_q;
	logic                       halt_q;

	assign addr      = i_ex_mem.alu_result[`MIPS_ADDRWIDTH-1:0];  // word address
	assign load_data = dmem[addr];

	always_ff @(posedge clock) begin
		if (i_run_en && i_ex_mem.valid && i_ex_mem.mem_write)
			dmem[addr] <= i_ex_mem.store_data;
		o_dm_dbg_data <= dmem[i_dm_dbg_addr];  // debug port reads independently of the core
	end

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wb_q   <= '0;
			halt_q <= 1'b0;
		end else if (i_restart) begin
			wb_q   <= '0;
			halt_q <= 1'b0;
		end else if (i_run_en) begin
			wb_q.reg_write  <= i_ex_mem.valid && i_ex_mem.reg_write;
			wb_q.write_reg  <= i_ex_mem.write_reg;
			wb_q.write_data <= i_ex_mem.mem_to_reg ? load_data : i_ex_mem.alu_result;
			halt_q          <= i_ex_mem.valid && i_ex_mem.halt;
		end
	end

	assign o_wb      = wb_q;
	assign o_wb_halt = halt_q;

endmodule

`default_nettype wire

/* hdl/pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module pipeline (
	input  wire                         clock,
	input  wire                         i_arst_n,
	input  wire                         i_start,
	input  wire                         i_im_we,
	input  wire [`MIPS_ADDRWIDTH-1:0]   i_im_addr,
	input  wire [`MIPS_NB_DATA-1:0]     i_im_data,
	input  wire [`MIPS_NB_REG-1:0]      i_reg_dbg_addr,
	input  wire [`MIPS_ADDRWIDTH-1:0]   i_dm_dbg_addr,
	output logic [`MIPS_NB_DATA-1:0]    o_reg_dbg_data,
	output logic [`MIPS_NB_DATA-1:0]    o_dm_dbg_data,
	output logic [`MIPS_ADDRWIDTH-1:0]  o_pc,
	output logic                        o_halt
);

	logic                       run_en;
	logic                       restart;
	logic                       wb_halt;
	logic                       stall;
	logic                       redirect;
	logic [`MIPS_ADDRWIDTH-1:0] redirect_pc;
	pipe_pkg::if_id_t           if_id;
	pipe_pkg::id_ex_t           id_ex;
	pipe_pkg::ex_mem_t          ex_mem;
	pipe_pkg::wb_t              wb;
	pipe_pkg::fwd_t             fwd;

	run_ctrl run_ctrl_i (
		.clock      (clock),
		.i_arst_n   (i_arst_n),
		.i_start    (i_start),
		.i_wb_halt  (wb_halt),
		.o_run_en   (run_en),
		.o_restart  (restart),
		.o_halt     (o_halt)
	);

	fetch_stage fetch_i (
		.clock          (clock),
		.i_arst_n       (i_arst_n),
		.i_run_en       (run_en),
		.i_restart      (restart),
		.i_stall        (stall),
		.i_redirect     (redirect),
		.i_redirect_pc  (redirect_pc),
		.i_im_we        (i_im_we),
		.i_im_addr      (i_im_addr),
		.i_im_data      (i_im_data),
		.o_if_id        (if_id),
		.o_pc           (o_pc)
	);

	decode_stage decode_i (
		.clock           (clock),
		.i_arst_n        (i_arst_n),
		.i_run_en        (run_en),
		.i_restart       (restart),
		.i_if_id         (if_id),
		.i_wb            (wb),
		.i_fwd           (fwd),
		.i_reg_dbg_addr  (i_reg_dbg_addr),
		.o_id_ex         (id_ex),
		.o_stall         (stall),
		.o_redirect      (redirect),
		.o_redirect_pc   (redirect_pc),
		.o_reg_dbg_data  (o_reg_dbg_data)
	);

	execute_stage execute_i (
		.clock      (clock),
		.i_arst_n   (i_arst_n),
		.i_run_en   (run_en),
		.i_restart  (restart),
		.i_id_ex    (id_ex),
		.i_wb       (wb),
		.o_ex_mem   (ex_mem),
		.o_fwd      (fwd)
	);

	memory_stage memory_i (
		.clock          (clock),
		.i_arst_n       (i_arst_n),
		.i_run_en       (run_en),
		.i_restart      (restart),
		.i_ex_mem       (ex_mem),
		.i_dm_dbg_addr  (i_dm_dbg_addr),
		.o_wb           (wb),
		.o_wb_halt      (wb_halt),
		.o_dm_dbg_data  (o_dm_dbg_data)
	);

endmodule

`default_nettype wire

/* sim/pipeline_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module pipeline_checker (
	input  wire                        clock,
	input  wire                        i_start,
	input  wire                        i_halt,
	input  wire [`MIPS_ADDRWIDTH-1:0]  i_pc,
	input  wire                        i_chk_reg,
	input  wire [`MIPS_NB_REG-1:0]     i_reg_addr,
	input  wire [`MIPS_NB_DATA-1:0]    i_exp_reg,
	input  wire [`MIPS_NB_DATA-1:0]    i_reg_data,
	input  wire                        i_chk_dm,
	input  wire [`MIPS_ADDRWIDTH-1:0]  i_dm_addr,
	input  wire [`MIPS_NB_DATA-1:0]    i_exp_dm,
	input  wire [`MIPS_NB_DATA-1:0]    i_dm_data,
	output int                         o_errors,
	output int                         o_tests_failed
);

	logic                       chk_reg_q = 1'b0;
	logic                       chk_dm_q  = 1'b0;
	logic [`MIPS_NB_REG-1:0]    reg_addr_q;
	logic [`MIPS_ADDRWIDTH-1:0] dm_addr_q;
	logic [`MIPS_NB_DATA-1:0]   exp_reg_q, exp_dm_q;
	logic                       start_q   = 1'b0;
	logic                       halt_last = 1'b0;
	int                         err_count = 0;
	int                         err_mark  = 0;    // err_count when the test began
	int                         tests_run = 0;
	int                         failed    = 0;

	// address and expected value of the read that lands next cycle
	always @(posedge clock) begin
		chk_reg_q  <= i_chk_reg;
		chk_dm_q   <= i_chk_dm;
		reg_addr_q <= i_reg_addr;
		dm_addr_q  <= i_dm_addr;
		exp_reg_q  <= i_exp_reg;
		exp_dm_q   <= i_exp_dm;
		start_q    <= i_start;
	end

	always @(negedge clock) begin
		if (chk_reg_q && i_reg_data !== exp_reg_q) begin
			$display("Mismatch at %0t: register r%0d reads %h, expected %h",
				$time, reg_addr_q, i_reg_data, exp_reg_q);
			err_count = err_count + 1;
		end
		if (chk_dm_q && i_dm_data !== exp_dm_q) begin
			$display("Mismatch at %0t: data word %0d reads %h, expected %h",
				$time, dm_addr_q, i_dm_data, exp_dm_q);
			err_count = err_count + 1;
		end
		if (start_q && i_pc !== '0) begin   // start restarts the program at word zero
			$display("Mismatch at %0t: pc reads %0d after start, expected 0", $time, i_pc);
			err_count = err_count + 1;
		end
		if (halt_last && !i_halt && !start_q) begin
			$display("o_halt went low at %0t although no new start was given", $time);
			err_count = err_count + 1;
		end
		halt_last = i_halt;
	end

	task automatic end_test(input string name, input int retired);
		int n;
		n         = err_count - err_mark;
		err_mark  = err_count;
		tests_run = tests_run + 1;
		if (n == 0) begin
			$display("test %0d %s: %0d instructions retired, ok", tests_run, name, retired);
		end else begin
			$display("test %0d %s: %0d instructions retired, %0d errors",
				tests_run, name, retired, n);
			failed = failed + 1;
		end
	endtask

	assign o_errors       = err_count;
	assign o_tests_failed = failed;

endmodule

`default_nettype wire

/* sim/tb_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module tb_pipeline;

	localparam int NT = 8;   // five directed programs and three random ones

	logic                       clock;
	logic                       arst_n;
	logic                       start;
	logic                       im_we;
	logic [`MIPS_ADDRWIDTH-1:0] im_addr;
	logic [`MIPS_NB_DATA-1:0]   im_data;
	logic [`MIPS_NB_REG-1:0]    reg_addr;
	logic [`MIPS_ADDRWIDTH-1:0] dm_addr;
	logic [`MIPS_NB_DATA-1:0]   reg_data, dm_data;
	logic [`MIPS_ADDRWIDTH-1:0] pc;
	logic                       halt;
	logic                       chk_reg, chk_dm;
	logic [`MIPS_NB_DATA-1:0]   exp_reg, exp_dm;
	int                         errors, tests_failed;

	logic [31:0] progs [NT][`MIPS_IM_DEPTH];
	int          lens [NT];
	string       names [NT];
	int          cur;
	logic [31:0] ref_regs [`MIPS_N_REGISTER];
	logic [31:0] ref_dmem [`MIPS_DM_DEPTH];
	bit          ref_dm_valid [`MIPS_DM_DEPTH];
	integer      seed;
	int          cycles = 0;
	int          limit  = 0;

	pipeline dut_i (
		.clock          (clock),
		.i_arst_n       (arst_n),
		.i_start        (start),
		.i_im_we        (im_we),
		.i_im_addr      (im_addr),
		.i_im_data      (im_data),
		.i_reg_dbg_addr (reg_addr),
		.i_dm_dbg_addr  (dm_addr),
		.o_reg_dbg_data (reg_data),
		.o_dm_dbg_data  (dm_data),
		.o_pc           (pc),
		.o_halt         (halt)
	);

	pipeline_checker checker_i (
		.clock          (clock),
		.i_start        (start),
		.i_halt         (halt),
		.i_pc           (pc),
		.i_chk_reg      (chk_reg),
		.i_reg_addr     (reg_addr),
		.i_exp_reg      (exp_reg),
		.i_reg_data     (reg_data),
		.i_chk_dm       (chk_dm),
		.i_dm_addr      (dm_addr),
		.i_exp_dm       (exp_dm),
		.i_dm_data      (dm_data),
		.o_errors       (errors),
		.o_tests_failed (tests_failed)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the core never reached HALT", limit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	function automatic logic [31:0] encode_r(input logic [5:0] funct, input int rd,
		input int rs, input int rt, input int sh);
		return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input int rt,
		input int rs, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic emit(input logic [31:0] w);
		progs[cur][lens[cur]] = w;
		lens[cur] = lens[cur] + 1;
	endtask

	// instruction level model, raw MIPS encodings
	function automatic int run_reference(input int t);
		int          pc_m, next, rs, rt, rd, dst, addr;
		logic [31:0] w, a, b, imm_s, imm_z, res, ea;
		bit          wr;
		pc_m = 0;
		for (int n = 1; n < 1000; n++) begin
			w     = progs[t][pc_m];
			rs    = int'(w[25:21]);
			rt    = int'(w[20:16]);
			rd    = int'(w[15:11]);
			a     = ref_regs[rs];
			b     = ref_regs[rt];
			imm_s = {{16{w[15]}}, w[15:0]};
			imm_z = {16'b0, w[15:0]};
			ea    = a + imm_s;
			addr  = int'(ea[5:0]);
			next  = (pc_m + 1) % 64;
			wr    = 1'b1;
			dst   = rt;
			res   = '0;
			case (w[31:26])
				6'h00: begin
					dst = rd;
					case (w[5:0])
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						6'h00: res = b << w[10:6];
						default: wr = 1'b0;
					endcase
				end
				6'h09: res = ea;
				6'h0c: res = a & imm_z;
				6'h0d: res = a | imm_z;
				6'h0f: res = {w[15:0], 16'b0};
				6'h23: res = ref_dmem[addr];
				6'h2b: begin
					wr                 = 1'b0;
					ref_dmem[addr]     = b;
					ref_dm_valid[addr] = 1'b1;
				end
				6'h04, 6'h05: begin
					wr = 1'b0;
					if ((a == b) == (w[31:26] == 6'h04))
						next = (pc_m + 1 + int'(imm_s[5:0])) % 64;
				end
				6'h02: begin
					wr   = 1'b0;
					next = int'(w[5:0]);
				end
				6'h3f: return n;
				default: wr = 1'b0;
			endcase
			if (wr && dst != 0)
				ref_regs[dst] = res;
			pc_m = next;
		end
		return -1;
	endfunction

	task automatic build_programs();
		logic [31:0] ra, rb, rimm;
		int          off;
		cur      = 0;
		names[0] = "alu_and_immediates";
		emit(encode_i(isa_pkg::ADDIU, 1, 0, 16'd5));
		emit(encode_i(isa_pkg::ADDIU, 2, 0, 16'hfffd));
		emit(encode_i(isa_pkg::ORI, 3, 0, 16'hf0f0));
		emit(encode_i(isa_pkg::LUI, 4, 0, 16'h1234));
		emit(encode_i(isa_pkg::ADDIU, 0, 0, 16'd7));   // r0 stays zero
		emit(encode_r(isa_pkg::SLT, 5, 2, 1, 0));
		emit(encode_r(isa_pkg::SUBU, 6, 1, 2, 0));
		emit(encode_r(isa_pkg::AND, 7, 3, 4, 0));
		emit(encode_r(isa_pkg::OR, 8, 3, 4, 0));
		emit(encode_r(isa_pkg::XOR, 9, 3, 1, 0));
		emit(encode_r(isa_pkg::SLL, 10, 0, 1, 4));
		emit(encode_i(isa_pkg::ANDI, 11, 3, 16'h00ff));
		emit(encode_r(isa_pkg::SLT, 12, 1, 2, 0));
		emit(encode_r(isa_pkg::ADDU, 13, 1, 2, 0));
		emit({isa_pkg::HALT, 26'b0});

		cur      = 1;
		names[1] = "dependent_chain";
		emit(encode_i(isa_pkg::ADDIU, 1, 0, 16'd1));
		emit(encode_r(isa_pkg::ADDU, 2, 1, 1, 0));
		emit(encode_r(isa_pkg::ADDU, 3, 2, 1, 0));
		emit(encode_r(isa_pkg::SUBU, 4, 3, 2, 0));
		emit(encode_r(isa_pkg::XOR, 5, 4, 3, 0));
		emit(encode_r(isa_pkg::ADDU, 5, 5, 5, 0));
		emit(encode_r(isa_pkg::SLL, 6, 0, 5, 2));
		emit(encode_r(isa_pkg::OR, 7, 6, 1, 0));
		emit(encode_i(isa_pkg::ADDIU, 8, 7, 16'd100));
		emit({isa_pkg::HALT, 26'b0});

		cur      = 2;
		names[2] = "store_load";
		emit(encode_i(isa_pkg::ADDIU, 1, 0, 16'h0055));
		emit(encode_i(isa_pkg::ADDIU, 2, 0, 16'd3));
		emit(encode_i(isa_pkg::SW, 1, 2, 16'd0));
		emit(encode_i(isa_pkg::SW, 2, 2, 16'd4));
		emit(encode_i(isa_pkg::LW, 3, 2, 16'd0));
		emit(encode_r(isa_pkg::ADDU, 4, 3, 3, 0));      // load-use
		emit(encode_i(isa_pkg::LW, 5, 2, 16'd4));
		emit(encode_i(isa_pkg::SW, 5, 0, 16'd10));
		emit(encode_i(isa_pkg::LW, 6, 0, 16'd10));
		emit(encode_i(isa_pkg::ADDIU, 6, 6, 16'd1));
		emit(encode_i(isa_pkg::SW, 6, 0, 16'd11));
		emit({isa_pkg::HALT, 26'b0});

		cur      = 3;
		names[3] = "branches_and_jump";
		emit(encode_i(isa_pkg::ADDIU, 1, 0, 16'd3));
		emit(encode_i(isa_pkg::ADDIU, 2, 0, 16'd3));
		emit(encode_i(isa_pkg::BEQ, 2, 1, 16'd1));      // taken, depends on r2
		emit(encode_i(isa_pkg::ADDIU, 10, 0, 16'd99));
		emit(encode_i(isa_pkg::BNE, 2, 1, 16'd1));      // not taken
		emit(encode_i(isa_pkg::ADDIU, 11, 0, 16'd7));
		emit(encode_i(isa_pkg::ADDIU, 3, 0, 16'd4));
		emit(encode_i(isa_pkg::BNE, 1, 3, 16'd1));
		emit(encode_i(isa_pkg::ADDIU, 12, 0, 16'd99));
		emit({isa_pkg::J, 26'd11});
		emit(encode_i(isa_pkg::ADDIU, 13, 0, 16'd99));
		emit(encode_i(isa_pkg::SW, 3, 0, 16'd20));
		emit(encode_i(isa_pkg::LW, 4, 0, 16'd20));
		emit(encode_i(isa_pkg::BEQ, 3, 4, 16'd1));      // branch on loaded value
		emit(encode_i(isa_pkg::ADDIU, 14, 0, 16'd99));
		emit(encode_i(isa_pkg::ADDIU, 15, 0, 16'd1));
		emit(encode_i(isa_pkg::ADDIU, 5, 0, 16'd0));
		emit(encode_i(isa_pkg::ADDIU, 5, 5, 16'd1));
		emit(encode_i(isa_pkg::BNE, 1, 5, 16'hfffe));   // loop back three times
		emit({isa_pkg::HALT, 26'b0});

		cur      = 4;
		names[4] = "second_program";
		emit(encode_i(isa_pkg::ADDIU, 20, 0, 16'h0077));
		emit(encode_r(isa_pkg::ADDU, 21, 20, 1, 0));
		emit(encode_i(isa_pkg::SW, 21, 0, 16'd30));
		emit({isa_pkg::HALT, 26'b0});

		for (int t = 5; t < NT; t++) begin
			cur      = t;
			names[t] = $sformatf("random_%0d", t - 4);
			ra       = $random(seed);
			rb       = $random(seed);
			rimm     = $random(seed);
			off      = int'(rimm[21:16]);
			emit(encode_i(isa_pkg::LUI, 1, 0, ra[31:16]));
			emit(encode_i(isa_pkg::ORI, 1, 1, ra[15:0]));
			emit(encode_i(isa_pkg::LUI, 2, 0, rb[31:16]));
			emit(encode_i(isa_pkg::ORI, 2, 2, rb[15:0]));
			emit(encode_r(isa_pkg::ADDU, 3, 1, 2, 0));
			emit(encode_r(isa_pkg::SUBU, 4, 1, 2, 0));
			emit(encode_r(isa_pkg::SLT, 5, 1, 2, 0));
			emit(encode_r(isa_pkg::XOR, 6, 3, 4, 0));
			emit(encode_r(isa_pkg::SLL, 7, 0, 6, int'(rimm[28:24])));
			emit(encode_r(isa_pkg::AND, 8, 1, 2, 0));
			emit(encode_r(isa_pkg::OR, 9, 8, 7, 0));
			emit(encode_i(isa_pkg::SW, 9, 0, 16'(off)));
			emit(encode_i(isa_pkg::LW, 10, 0, 16'(off)));
			emit(encode_i(isa_pkg::ADDIU, 11, 10, rimm[15:0]));
			emit(encode_i(isa_pkg::BEQ, 0, 5, 16'd1));
			emit(encode_i(isa_pkg::ADDIU, 12, 0, 16'd1));
			emit(encode_i(isa_pkg::ADDIU, 13, 11, 16'hffff));
			emit({isa_pkg::HALT, 26'b0});
		end
	endtask

	task automatic run_test(input int t);
		int retired;
		for (int i = 0; i < lens[t]; i++) begin
			next_cycle();
			im_we   = 1'b1;
			im_addr = 6'(i);
			im_data = progs[t][i];
		end
		next_cycle();
		im_we = 1'b0;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		retired = run_reference(t);
		while (!halt)
			next_cycle();
		for (int i = 0; i < `MIPS_DM_DEPTH; i++) begin
			next_cycle();
			reg_addr = 5'(i);
			chk_reg  = (i < `MIPS_N_REGISTER);
			exp_reg  = ref_regs[i % `MIPS_N_REGISTER];
			dm_addr  = 6'(i);
			chk_dm   = ref_dm_valid[i];    // never written words are undefined
			exp_dm   = ref_dmem[i];
		end
		next_cycle();
		chk_reg = 1'b0;
		chk_dm  = 1'b0;
		next_cycle();
		next_cycle();
		checker_i.end_test(names[t], retired);
	endtask

	initial begin
		int total;
		arst_n   = 1'b0;
		start    = 1'b0;
		im_we    = 1'b0;
		im_addr  = '0;
		im_data  = '0;
		reg_addr = '0;
		dm_addr  = '0;
		chk_reg  = 1'b0;
		chk_dm   = 1'b0;
		exp_reg  = '0;
		exp_dm   = '0;
		seed     = 32'h4b94_6c3d;
		for (int i = 0; i < `MIPS_N_REGISTER; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < `MIPS_DM_DEPTH; i++) begin
			ref_dmem[i]     = '0;
			ref_dm_valid[i] = 1'b0;
		end
		for (int t = 0; t < NT; t++)
			lens[t] = 0;
		build_programs();
		total = 0;
		for (int t = 0; t < NT; t++)
			total = total + lens[t];
		limit = 20 * total + NT * (`MIPS_DM_DEPTH + 8) + 20;   // sweep plus reset
		repeat (10) @(posedge clock);
		#1 arst_n = 1'b1;
		for (int t = 0; t < NT; t++)
			run_test(t);
		$display("%0d tests run, %0d failed, %0d errors", NT, tests_failed, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/run_ctrl.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipeline.sv
sim/pipeline_checker.sv
sim/tb_pipeline.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_pipeline
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^all tests passed$$" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
